/* logic/core_pkg.sv */
/* Core datapath package
   Word, address and register-index types plus the forwarding select codes */
package core_pkg;

	localparam int XLEN     = 32;	// Data word width
	localparam int NUM_REGS = 32;	// Architectural registers x0..x31

	typedef logic [XLEN-1:0]             word_t;
	typedef logic [XLEN-1:0]             pc_t;	// Byte address, word aligned
	typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

	// Operand source for the EXE forwarding muxes
	localparam logic [1:0] FWD_REG = 2'd0;	// Value latched in ID/EXE
	localparam logic [1:0] FWD_MEM = 2'd1;	// Result sitting in MEM
	localparam logic [1:0] FWD_WB  = 2'd2;	// Result sitting in WB

endpackage

/* logic/isa_pkg.sv */
/* RV32I subset package
   Opcodes, funct3 codes, field positions and the control encodings */
package isa_pkg;

	typedef enum logic [6:0] {
		OPC_RTYPE  = 7'b0110011,
		OPC_ITYPE  = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,	// LW only
		OPC_STORE  = 7'b0100011,	// SW only
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
		ALU_PASS_B	// LUI, B operand is the U immediate
	} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JAL, BR_JALR
	} br_type_e;

	// Instruction field LSB positions
	localparam int RD_POS  = 7;
	localparam int F3_POS  = 12;
	localparam int RS1_POS = 15;
	localparam int RS2_POS = 20;
	localparam int F7_POS  = 25;

	// funct3, ALU group
	localparam logic [2:0] F3_ADD  = 3'b000;	// ADD/SUB/ADDI
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	// funct3, branch group
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;

	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;	// ADDI x0,x0,0

endpackage

/* logic/fetch_stage.sv */
/* Fetch stage
   PC register, next-PC select and the IF/ID pipeline register */
`timescale 1ns/1ps

module fetch_stage #(
	parameter core_pkg::pc_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,		// Load-use hold
	input  logic            flush,		// Kill the fetched instruction
	input  logic            exe_redirect,
	input  core_pkg::pc_t   exe_target,
	input  core_pkg::word_t imem_data,
	output core_pkg::pc_t   imem_addr,
	output core_pkg::pc_t   id_pc,
	output core_pkg::word_t id_instr
);
	import core_pkg::*;
	import isa_pkg::*;

	pc_t pc_q;	// Address being fetched
	pc_t pc_next;

	assign imem_addr = pc_q;

	// Redirect first, then hold, else static not-taken
	always_comb begin
		if (exe_redirect)
			pc_next = exe_target;
		else if (stall)
			pc_next = pc_q;
		else
			pc_next = pc_q + pc_t'(4);
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc_q <= RESET_PC;
		else
			pc_q <= pc_next;
	end

	//////////////////////////////
	// IF/ID register

	always_ff @(posedge clk) begin
		if (rst || flush)
			id_instr <= NOP_INSTR;	// Wrong-path slot becomes a NOP
		else if (!stall)
			id_instr <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_pc <= pc_q;		// PC of the instr entering ID
	end

endmodule

/* logic/regfile.sv */
/* Integer register file
   32 x 32 bits, two combinational reads, one write, x0 reads as zero */
`timescale 1ns/1ps

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,		// From WB
	input  core_pkg::reg_addr_t rd,
	input  core_pkg::word_t     wdata,
	input  core_pkg::reg_addr_t rs1,
	input  core_pkg::reg_addr_t rs2,
	output core_pkg::word_t     rdata1,
	output core_pkg::word_t     rdata2
);
	import core_pkg::*;

	word_t regs [NUM_REGS];
	logic  wr_live;		// A write that lands this cycle

	// x0 is never written, so it keeps its reset zero
	assign wr_live = we && (rd != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[rd] <= wdata;
		end
	end

	// Bypass so ID sees the value WB writes this cycle
	assign rdata1 = (wr_live && rd == rs1) ? wdata : regs[rs1];
	assign rdata2 = (wr_live && rd == rs2) ? wdata : regs[rs2];

endmodule

/* logic/decode_stage.sv */
/* Decode stage
   Control decode, immediate build and the ID/EXE pipeline register */
`timescale 1ns/1ps

module decode_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  logic                flush,
	input  core_pkg::pc_t       id_pc,
	input  core_pkg::word_t     id_instr,
	input  core_pkg::word_t     rdata1,		// Regfile port A
	input  core_pkg::word_t     rdata2,		// Regfile port B
	output core_pkg::reg_addr_t id_rs1,
	output core_pkg::reg_addr_t id_rs2,
	output core_pkg::pc_t       exe_pc,
	output core_pkg::word_t     exe_rs1_val,
	output core_pkg::word_t     exe_rs2_val,
	output core_pkg::word_t     exe_imm,
	output core_pkg::reg_addr_t exe_rs1,
	output core_pkg::reg_addr_t exe_rs2,
	output core_pkg::reg_addr_t exe_rd,
	output isa_pkg::alu_op_e    exe_alu_op,
	output logic                exe_use_imm,
	output isa_pkg::br_type_e   exe_br_type,
	output isa_pkg::wb_sel_e    exe_wb_sel,
	output logic                exe_reg_we,
	output logic                exe_mem_we,
	output logic                exe_is_load
);
	import core_pkg::*;
	import isa_pkg::*;

	localparam int RW = $bits(reg_addr_t);

	word_t      dec_instr;		// What actually enters EXE
	opcode_e    opcode;
	logic [2:0] funct3;
	word_t      i_imm, s_imm, b_imm, u_imm, j_imm;
	word_t      imm;
	alu_op_e    alu_op;
	br_type_e   br_type;
	wb_sel_e    wb_sel;
	logic       use_imm;
	logic       reg_we;
	logic       mem_we;
	logic       is_load;

	// Shared by R-type and I-type, sub only set for R-type
	function automatic alu_op_e f3_alu(input logic [2:0] f3, input logic sub);
		case (f3)
			F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;	// Shifts not supported
		endcase
	endfunction

	// Hazard check uses the real instr, even while it is held
	assign id_rs1 = id_instr[RS1_POS +: RW];
	assign id_rs2 = id_instr[RS2_POS +: RW];

	// Stall and flush both turn the slot into a NOP
	assign dec_instr = (stall || flush) ? NOP_INSTR : id_instr;
	assign opcode    = opcode_e'(dec_instr[6:0]);
	assign funct3    = dec_instr[F3_POS +: 3];

	assign i_imm = {{20{dec_instr[31]}}, dec_instr[31:20]};
	assign s_imm = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
	assign b_imm = {{19{dec_instr[31]}}, dec_instr[31], dec_instr[7],
		dec_instr[30:25], dec_instr[11:8], 1'b0};
	assign u_imm = {dec_instr[31:12], 12'b0};
	assign j_imm = {{11{dec_instr[31]}}, dec_instr[31], dec_instr[19:12],
		dec_instr[20], dec_instr[30:21], 1'b0};

	always_comb begin
		alu_op  = ALU_ADD;	// Defaults describe a NOP
		br_type = BR_NONE;
		wb_sel  = WB_ALU;
		imm     = i_imm;
		use_imm = 1'b0;
		reg_we  = 1'b0;
		mem_we  = 1'b0;
		is_load = 1'b0;
		case (opcode)
			OPC_RTYPE: begin
				alu_op = f3_alu(funct3, dec_instr[F7_POS+5]);
				reg_we = 1'b1;
			end
			OPC_ITYPE: begin
				alu_op  = f3_alu(funct3, 1'b0);
				use_imm = 1'b1;
				reg_we  = 1'b1;
			end
			OPC_LUI: begin
				alu_op  = ALU_PASS_B;
				imm     = u_imm;
				use_imm = 1'b1;
				reg_we  = 1'b1;
			end
			OPC_LOAD: begin
				wb_sel  = WB_LOAD;
				use_imm = 1'b1;
				reg_we  = 1'b1;
				is_load = 1'b1;
			end
			OPC_STORE: begin
				imm     = s_imm;
				use_imm = 1'b1;
				mem_we  = 1'b1;
			end
			OPC_BRANCH: begin
				imm = b_imm;
				case (funct3)
					F3_BEQ:  br_type = BR_EQ;
					F3_BNE:  br_type = BR_NE;
					F3_BLT:  br_type = BR_LT;
					F3_BGE:  br_type = BR_GE;
					default: br_type = BR_NONE;	// Unsigned branches dropped
				endcase
			end
			OPC_JAL: begin
				br_type = BR_JAL;
				imm     = j_imm;
				wb_sel  = WB_PC4;	// Link value
				reg_we  = 1'b1;
			end
			OPC_JALR: begin
				br_type = BR_JALR;
				wb_sel  = WB_PC4;
				reg_we  = 1'b1;
			end
			default: ;		// Unknown opcode runs as a NOP
		endcase
	end

	//////////////////////////////
	// ID/EXE register

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_rd      <= '0;
			exe_br_type <= BR_NONE;
			exe_reg_we  <= 1'b0;
			exe_mem_we  <= 1'b0;
			exe_is_load <= 1'b0;
		end else begin
			exe_rd      <= dec_instr[RD_POS +: RW];
			exe_br_type <= br_type;
			exe_reg_we  <= reg_we;
			exe_mem_we  <= mem_we;
			exe_is_load <= is_load;
		end
	end

	always_ff @(posedge clk) begin
		exe_pc      <= id_pc;
		exe_rs1_val <= rdata1;
		exe_rs2_val <= rdata2;
		exe_imm     <= imm;
		exe_rs1     <= dec_instr[RS1_POS +: RW];	// Zero in a bubble
		exe_rs2     <= dec_instr[RS2_POS +: RW];
		exe_alu_op  <= alu_op;
		exe_use_imm <= use_imm;
		exe_wb_sel  <= wb_sel;
	end

endmodule

/* logic/hazard_unit.sv */
/* Hazard unit
   Forwarding selects for EXE, load-use stall and redirect flush */
`timescale 1ns/1ps

module hazard_unit (
	input  core_pkg::reg_addr_t id_rs1,
	input  core_pkg::reg_addr_t id_rs2,
	input  core_pkg::reg_addr_t exe_rs1,
	input  core_pkg::reg_addr_t exe_rs2,
	input  core_pkg::reg_addr_t exe_rd,
	input  logic                exe_is_load,
	input  logic                exe_redirect,	// Taken branch or jump in EXE
	input  core_pkg::reg_addr_t mem_rd,
	input  logic                mem_reg_we,
	input  core_pkg::reg_addr_t wb_rd,
	input  logic                wb_we,
	output logic [1:0]          fwd_a_sel,
	output logic [1:0]          fwd_b_sel,
	output logic                stall,
	output logic                flush
);
	import core_pkg::*;

	// MEM holds the younger result so it wins over WB
	function automatic logic [1:0] fwd_pick(input reg_addr_t rs);
		if (rs == '0)
			return FWD_REG;		// x0 always reads zero
		else if (mem_reg_we && mem_rd == rs)
			return FWD_MEM;
		else if (wb_we && wb_rd == rs)
			return FWD_WB;
		else
			return FWD_REG;
	endfunction

	always_comb begin
		fwd_a_sel = fwd_pick(exe_rs1);
		fwd_b_sel = fwd_pick(exe_rs2);
	end

	// Load data only exists in MEM, so the user waits one cycle
	assign stall = exe_is_load && (exe_rd != '0) &&
		(exe_rd == id_rs1 || exe_rd == id_rs2);

	assign flush = exe_redirect;	// Kill IF/ID and ID/EXE contents

endmodule

/* logic/execute_stage.sv */
/* Execute stage
   Operand forwarding, ALU, branch resolve and the EXE/MEM register */
`timescale 1ns/1ps

module execute_stage (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::pc_t       exe_pc,
	input  core_pkg::word_t     exe_rs1_val,
	input  core_pkg::word_t     exe_rs2_val,
	input  core_pkg::word_t     exe_imm,
	input  core_pkg::reg_addr_t exe_rd,
	input  isa_pkg::alu_op_e    exe_alu_op,
	input  logic                exe_use_imm,
	input  isa_pkg::br_type_e   exe_br_type,
	input  isa_pkg::wb_sel_e    exe_wb_sel,
	input  logic                exe_reg_we,
	input  logic                exe_mem_we,
	input  logic [1:0]          fwd_a_sel,
	input  logic [1:0]          fwd_b_sel,
	input  core_pkg::word_t     mem_result,		// MEM-stage forward source
	input  core_pkg::word_t     wb_data,		// WB-stage forward source
	output logic                exe_redirect,
	output core_pkg::pc_t       exe_target,
	output core_pkg::word_t     mem_alu_out,
	output core_pkg::word_t     mem_store_val,
	output core_pkg::reg_addr_t mem_rd,
	output logic                mem_reg_we,
	output logic                mem_mem_we,
	output isa_pkg::wb_sel_e    mem_wb_sel,
	output core_pkg::pc_t       mem_pc4
);
	import core_pkg::*;
	import isa_pkg::*;

	word_t op_a;		// rs1 after forwarding
	word_t op_b;		// rs2 after forwarding, also SW data
	word_t alu_b;
	word_t alu_out;
	word_t jalr_sum;

	function automatic word_t fwd_mux(input logic [1:0] sel, input word_t reg_val,
		input word_t mem_val, input word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a  = fwd_mux(fwd_a_sel, exe_rs1_val, mem_result, wb_data);
	assign op_b  = fwd_mux(fwd_b_sel, exe_rs2_val, mem_result, wb_data);
	assign alu_b = exe_use_imm ? exe_imm : op_b;

	always_comb begin
		case (exe_alu_op)
			ALU_SUB:    alu_out = op_a - alu_b;
			ALU_AND:    alu_out = op_a & alu_b;
			ALU_OR:     alu_out = op_a | alu_b;
			ALU_XOR:    alu_out = op_a ^ alu_b;
			ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(alu_b));
			ALU_SLTU:   alu_out = word_t'(op_a < alu_b);
			ALU_PASS_B: alu_out = alu_b;
			default:    alu_out = op_a + alu_b;		// ADD, also load/store address
		endcase
	end

	//////////////////////////////
	// Branch resolve

	always_comb begin
		case (exe_br_type)
			BR_EQ:   exe_redirect = (op_a == op_b);
			BR_NE:   exe_redirect = (op_a != op_b);
			BR_LT:   exe_redirect = $signed(op_a) < $signed(op_b);
			BR_GE:   exe_redirect = $signed(op_a) >= $signed(op_b);
			BR_JAL,
			BR_JALR: exe_redirect = 1'b1;
			default: exe_redirect = 1'b0;
		endcase
	end

	// JALR drops bit 0 of rs1+imm
	assign jalr_sum   = op_a + exe_imm;
	assign exe_target = (exe_br_type == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
		: exe_pc + exe_imm;

	//////////////////////////////
	// EXE/MEM register

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_rd     <= '0;
			mem_reg_we <= 1'b0;
			mem_mem_we <= 1'b0;
		end else begin
			mem_rd     <= exe_rd;
			mem_reg_we <= exe_reg_we;
			mem_mem_we <= exe_mem_we;	// One-cycle store pulse
		end
	end

	always_ff @(posedge clk) begin
		mem_alu_out   <= alu_out;
		mem_store_val <= op_b;
		mem_wb_sel    <= exe_wb_sel;
		mem_pc4       <= exe_pc + pc_t'(4);	// Link value for JAL/JALR
	end

endmodule

/* logic/mem_wb_stage.sv */
/* Memory and writeback stage
   Drives the data port, picks the result and holds the MEM/WB register */
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::word_t     mem_alu_out,
	input  core_pkg::word_t     mem_store_val,
	input  core_pkg::reg_addr_t mem_rd,
	input  logic                mem_reg_we,
	input  logic                mem_mem_we,
	input  isa_pkg::wb_sel_e    mem_wb_sel,
	input  core_pkg::pc_t       mem_pc4,
	input  core_pkg::word_t     dmem_rdata,		// Same-cycle read
	output core_pkg::word_t     dmem_addr,
	output core_pkg::word_t     dmem_wdata,
	output logic                dmem_we,
	output core_pkg::word_t     mem_result,
	output logic                wb_we,
	output core_pkg::reg_addr_t wb_rd,
	output core_pkg::word_t     wb_data
);
	import core_pkg::*;
	import isa_pkg::*;

	// Word access only, address straight from the ALU
	assign dmem_addr  = mem_alu_out;
	assign dmem_wdata = mem_store_val;
	assign dmem_we    = mem_mem_we;

	// Result picked here so loads can forward from MEM
	always_comb begin
		case (mem_wb_sel)
			WB_LOAD: mem_result = dmem_rdata;
			WB_PC4:  mem_result = mem_pc4;
			default: mem_result = mem_alu_out;
		endcase
	end

	//////////////////////////////
	// MEM/WB register

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_we <= mem_reg_we;
			wb_rd <= mem_rd;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= mem_result;		// Regfile write data and WB forward
	end

endmodule

/* logic/riscv_core.sv */
/* Five-stage RV32I core
   Connects IF, ID, EXE, MEM/WB, the register file and the hazard unit */
`timescale 1ns/1ps

module riscv_core #(
	parameter core_pkg::pc_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst,
	output core_pkg::pc_t   imem_addr,
	input  core_pkg::word_t imem_data,
	output core_pkg::word_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	output logic            dmem_we,
	input  core_pkg::word_t dmem_rdata
);
	import core_pkg::*;
	import isa_pkg::*;

	// ID stage
	pc_t       id_pc;
	word_t     id_instr;
	reg_addr_t id_rs1, id_rs2;
	word_t     rdata1, rdata2;

	// EXE stage
	pc_t       exe_pc;
	word_t     exe_rs1_val, exe_rs2_val, exe_imm;
	reg_addr_t exe_rs1, exe_rs2, exe_rd;
	alu_op_e   exe_alu_op;
	logic      exe_use_imm;
	br_type_e  exe_br_type;
	wb_sel_e   exe_wb_sel;
	logic      exe_reg_we, exe_mem_we, exe_is_load;
	logic      exe_redirect;
	pc_t       exe_target;

	// MEM stage
	word_t     mem_alu_out, mem_store_val, mem_result;
	reg_addr_t mem_rd;
	logic      mem_reg_we, mem_mem_we;
	wb_sel_e   mem_wb_sel;
	pc_t       mem_pc4;

	// WB stage
	logic      wb_we;
	reg_addr_t wb_rd;
	word_t     wb_data;

	// Hazard control
	logic [1:0] fwd_a_sel, fwd_b_sel;
	logic       stall, flush;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (.*);

	regfile regfile_inst (
		.clk    (clk),
		.rst    (rst),
		.we     (wb_we),
		.rd     (wb_rd),
		.wdata  (wb_data),
		.rs1    (id_rs1),
		.rs2    (id_rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	decode_stage  decode_stage_inst  (.*);
	hazard_unit   hazard_unit_inst   (.*);
	execute_stage execute_stage_inst (.*);
	mem_wb_stage  mem_wb_stage_inst  (.*);

endmodule

/* dv/tb_programs.svh */
/* Test program builder
   Instruction encoders, LFSR and the assembler that fills imem and the store list */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};	// ADDI, LW, JALR
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};	// SW
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Fibonacci LFSR with taps 32/22/2/1 and one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic        fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		v    = {v[30:0], fb};
	end
	return v;
endfunction

task automatic put(input logic [31:0] instr);
	imem[asm_pc[9:2]] = instr;
	asm_pc += 4;
endtask

// SW rs2 to an absolute address and expect it in order
task automatic store(input logic [4:0] rs2);
	put(enc_s(st_addr[11:0], rs2, 5'd0));
	exp_addr.push_back(st_addr);
	exp_data.push_back(rv[rs2]);
	exp_mem[st_addr[10:2]] = rv[rs2];
	st_addr += 4;
endtask

// Taken branch over two marker stores that must never show up
task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2);
	put(enc_b(13'd12, rs2, rs1, f3));
	put(enc_s(12'h7f0, 5'd11, 5'd0));
	put(enc_s(12'h7f4, 5'd11, 5'd0));
endtask

task automatic build_program();
	logic [4:0]  dst, prv, prv2;
	logic [31:0] a, b, r, imm, q;
	logic [2:0]  f3;
	logic [6:0]  f7;
	int          sel;
	// Seed two registers, then a dependent chain
	imm = rand_bits(20) << 12;
	put({imm[31:12], 5'd1, 7'b0110111});	// LUI x1
	rv[1] = imm;
	store(5'd1);
	imm = rand_bits(12);
	put(enc_i(imm[11:0], 5'd1, 3'b000, 5'd2, 7'b0010011));
	rv[2] = rv[1] + {{20{imm[11]}}, imm[11:0]};
	store(5'd2);
	prv  = 5'd2;
	prv2 = 5'd1;
	for (int k = 0; k < 20; k++) begin
		dst = 5'(3 + k % 5);	// x3..x7
		a   = rv[prv];
		b   = rv[prv2];
		sel = int'(rand_bits(4)) % 9;
		f7  = 7'b0;
		f3  = 3'b000;
		case (sel)
			0: begin	// ADDI
				imm = rand_bits(12);
				r   = a + {{20{imm[11]}}, imm[11:0]};
				put(enc_i(imm[11:0], prv, 3'b000, dst, 7'b0010011));
			end
			8: begin	// LUI
				imm = rand_bits(20);
				r   = {imm[19:0], 12'b0};
				put({imm[19:0], dst, 7'b0110111});
			end
			default: begin
				case (sel)
					1: r = a + b;
					2: begin
						f7 = 7'b0100000;
						r  = a - b;
					end
					3: begin
						f3 = 3'b111;
						r  = a & b;
					end
					4: begin
						f3 = 3'b110;
						r  = a | b;
					end
					5: begin
						f3 = 3'b100;
						r  = a ^ b;
					end
					6: begin
						f3 = 3'b010;
						r  = {31'b0, $signed(a) < $signed(b)};
					end
					default: begin
						f3 = 3'b011;
						r  = {31'b0, a < b};
					end
				endcase
				put(enc_r(f7, prv2, prv, f3, dst));
			end
		endcase
		rv[dst] = r;
		store(dst);
		prv2 = prv;
		prv  = dst;
	end
	arith_words = int'((asm_pc - RESET_PC) >> 2);

	//////////////////////////////
	// Load-use into the ALU and into store data
	put(enc_i(12'h100, 5'd0, 3'b010, 5'd8, 7'b0000011));
	rv[8] = exp_mem[9'h40];
	put(enc_r(7'b0, 5'd1, 5'd8, 3'b000, 5'd9));	// ADD x9,x8,x1
	rv[9] = rv[8] + rv[1];
	store(5'd9);
	put(enc_i(12'h104, 5'd0, 3'b010, 5'd10, 7'b0000011));
	rv[10] = exp_mem[9'h41];
	store(5'd10);

	//////////////////////////////
	// Branches
	put(enc_i(12'd5, 5'd0, 3'b000, 5'd11, 7'b0010011));
	rv[11] = 32'd5;
	put(enc_i(12'hffd, 5'd0, 3'b000, 5'd12, 7'b0010011));	// -3
	rv[12] = 32'hffff_fffd;
	branch_skip(3'b000, 5'd11, 5'd11);	// BEQ
	branch_skip(3'b100, 5'd12, 5'd11);	// BLT
	branch_skip(3'b101, 5'd11, 5'd12);	// BGE
	put(enc_b(13'd8, 5'd11, 5'd11, 3'b001));	// BNE falls through
	store(5'd11);

	//////////////////////////////
	// Jumps
	rv[13] = asm_pc + 4;
	put(enc_j(21'd8, 5'd13));
	put(enc_s(12'h7f8, 5'd11, 5'd0));	// Skipped
	store(5'd13);
	q = asm_pc;	// ADDI q, JALR q+4, marker q+8, target q+12
	put(enc_i(12'(q + 12), 5'd0, 3'b000, 5'd14, 7'b0010011));
	put(enc_i(12'd1, 5'd14, 3'b000, 5'd15, 7'b1100111));	// Odd sum so bit 0 gets dropped
	put(enc_s(12'h7fc, 5'd11, 5'd0));
	rv[15] = q + 8;
	store(5'd15);
	end_pc = asm_pc;
	put(enc_j(21'd0, 5'd0));	// Self-loop
	prog_words = int'(asm_pc >> 2);
endtask

`endif

/* dv/tb_riscv_core.sv */
/* Testbench for the five-stage core
   Memory models, in-order store checking, fetch stepping and a watchdog */
`timescale 1ns/1ps

module tb_riscv_core;

	localparam logic [31:0] RESET_PC = 32'h0;

	logic        clk;
	logic        rst;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [512];
	logic [31:0] exp_mem [512];	// Model of data memory
	logic [31:0] rv [32];		// Model of the register file
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] lfsr = 32'h33331f91;
	logic [31:0] asm_pc;
	logic [31:0] st_addr;
	logic [31:0] end_pc;
	int          arith_words;
	int          prog_words;
	int          rst_edges;

	`include "tb_programs.svh"

	riscv_core #(.RESET_PC(RESET_PC)) riscv_core_inst (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	always #5 clk = ~clk;

	// Combinational reads, word addressed
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[10:2]];

	always @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[10:2]] <= dmem_wdata;
		if (rst)
			rst_edges <= rst_edges + 1;
	end

	task automatic fail_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got %h expected %h", name, got, exp);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic fail_text(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// Word fetched in a given cycle with one PC hold per load-use pair
	function automatic int fetch_word(input int cyc);
		int w;
		w = cyc;
		if (cyc >= arith_words + 3)	// LW x8 meets its ADD
			w--;
		if (cyc >= arith_words + 7)	// LW x10 meets its SW
			w--;
		return w;
	endfunction

	//////////////////////////////
	// Store checker

	always @(posedge clk) begin
		if (rst) begin
			if (rst_edges > 0) begin	// Pipeline state known after the first edge
				assert (!dmem_we) else fail_text("Store pulse seen during reset");
				assert (imem_addr == RESET_PC)
					else fail_value("imem_addr", imem_addr, RESET_PC);
			end
		end else if (dmem_we) begin
			assert (exp_addr.size() > 0)
				else fail_text("Store seen after the last expected one");
			assert (dmem_addr == exp_addr[0])
				else fail_value("dmem_addr", dmem_addr, exp_addr[0]);
			assert (dmem_wdata == exp_data[0])
				else fail_value("dmem_wdata", dmem_wdata, exp_data[0]);
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
	end

	// Watchdog bound from the program length
	initial begin
		wait (prog_words > 0);
		repeat (prog_words * 4 + 100) @(posedge clk);
		fail_text("Timeout, program never reached its final loop");
	end

	initial begin
		int          cyc;
		logic [31:0] exp_pc;
		clk        = 1'b0;
		rst        = 1'b1;
		rst_edges  = 0;
		prog_words = 0;
		asm_pc     = RESET_PC;
		st_addr    = 32'h100;
		for (int i = 0; i < 256; i++)
			imem[i] = 32'h0000_0013 | (32'(i) << 7);	// ALU immediates, rd and funct3 from index
		for (int i = 0; i < 512; i++) begin
			dmem[i]    = 32'h5a3c_0000 ^ (i * 32'h9e37_79b1);
			exp_mem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			rv[i] = '0;
		build_program();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Fetch steps by 4 and holds once per load-use until the first redirect
		cyc = 0;
		while (imem_addr != end_pc) begin
			if (cyc < arith_words + 12) begin	// BEQ moves the PC in that cycle
				exp_pc = RESET_PC + 32'(fetch_word(cyc) * 4);
				assert (imem_addr == exp_pc) else fail_value("imem_addr", imem_addr, exp_pc);
			end
			cyc++;
			@(negedge clk);
		end
		repeat (6) @(negedge clk);	// Drain stores ahead of the loop

		if (exp_addr.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_text("Program ended with expected stores left over");
		end
	end

endmodule

/* riscv_pipe.f */
+incdir+dv
logic/core_pkg.sv
logic/isa_pkg.sv
logic/fetch_stage.sv
logic/regfile.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/riscv_core.sv
dv/tb_riscv_core.sv

/* Makefile */
# Verilator build and run for the riscv_pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= riscv_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
